// File: src.f
cpu_pkg.sv
cpu_ifs.sv
baud_timer.sv
upload_rx.sv
instruction_decoder.sv
registers.sv
alu.sv
memory.sv
control_unit.sv
cpu.sv
cpu_tb.sv

// File: Makefile
VERILATOR    ?= verilator
TOP          ?= cpu_tb
CLKS_PER_BIT ?= 8
SEED_FLAGS   ?=
VFLAGS       ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, fails unless the pass line appears"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP CLKS_PER_BIT SEED_FLAGS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GCLKS_PER_BIT=$(CLKS_PER_BIT) -f src.f
	@out="$$(./obj_dir/V$(TOP) $(SEED_FLAGS))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb #(
    parameter int CLKS_PER_BIT = 8
);
    import cpu_pkg::*;

    localparam int CLK_NS    = 10;
    localparam int MAX_WORDS = 64;
    localparam int MAX_STEPS = 2000;
    localparam int N_TESTS   = 5;
    localparam int SEED      = 32'h0f6f_ba6b;
    // one frame is start bit, eight data bits and stop bit
    localparam longint FRAME_NS    = 10 * CLKS_PER_BIT * CLK_NS;
    localparam longint TEST_NS     = (1 + 4 * MAX_WORDS) * FRAME_NS
                                     + 5 * MAX_STEPS * CLK_NS + 100 * CLK_NS;
    localparam longint WATCHDOG_NS = 2 * N_TESTS * TEST_NS;

    logic        clk;
    logic        reset;
    logic        rx;
    logic [15:0] display_out;
    logic        display_valid;
    logic        halted;

    word_t       prog[$];
    logic [15:0] expected[$];
    int          seen;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        uploading;

    cpu #(.CLKS_PER_BIT(CLKS_PER_BIT), .MEM_WORDS(256)) dut (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .display_out  (display_out),
        .display_valid(display_valid),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // instruction encoders
    function automatic word_t encode(input logic [3:0] op, input int rd, input int rs,
                                     input int rt, input int imm);
        return {op, rd[3:0], rs[3:0], rt[3:0], imm[15:0]};
    endfunction

    function automatic word_t alu_instr(input int fn, input int rd, input int rs, input int rt);
        return encode(OP_ALU, rd, rs, rt, fn);
    endfunction

    function automatic word_t addi(input int rd, input int rs, input int imm);
        return encode(OP_ADDI, rd, rs, 0, imm);
    endfunction

    function automatic word_t lui(input int rd, input int imm);
        return encode(OP_LUI, rd, 0, 0, imm);
    endfunction

    // r0 minus 4 wraps to the display address
    function automatic word_t show(input int rt);
        return encode(OP_SW, 0, 0, rt, -4);
    endfunction

    function automatic word_t halt_instr();
        return encode(OP_HALT, 0, 0, 0, 0);
    endfunction

    function automatic word_t alu_ref(input logic [3:0] fn, input word_t a, input word_t b);
        case (fn)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    // instruction-set model, fills expected and returns instructions before HALT
    function automatic int run_model();
        word_t regs [16];
        word_t mem [256];
        word_t ir;
        word_t a;
        word_t b;
        word_t imm;
        word_t addr;
        int    pc;
        int    next;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        expected.delete();
        pc = 0;
        for (int steps = 0; steps < MAX_STEPS; steps++) begin
            ir   = mem[pc & 255];
            a    = regs[ir[23:20]];
            b    = regs[ir[19:16]];
            imm  = {{16{ir[15]}}, ir[15:0]};
            addr = a + imm;
            next = pc + 1;
            case (ir[31:28])
                OP_ALU:  regs[ir[27:24]] = alu_ref(ir[3:0], a, b);
                OP_ADDI: regs[ir[27:24]] = a + imm;
                OP_LUI:  regs[ir[27:24]] = {ir[15:0], 16'h0000};
                OP_LW:   regs[ir[27:24]] = mem[addr[9:2]];
                OP_SW: begin
                    if (addr == DISPLAY_ADDR) begin
                        expected.push_back(b[15:0]);
                    end else begin
                        mem[addr[9:2]] = b;
                    end
                end
                OP_BEQ:  if (a == b) next = pc + 1 + int'($signed(imm));
                OP_BNE:  if (a != b) next = pc + 1 + int'($signed(imm));
                OP_JAL: begin
                    regs[ir[27:24]] = word_t'((pc + 1) * 4);
                    next = pc + 1 + int'($signed(imm));
                end
                OP_JR:   next = int'(a >> 2);
                default: return steps;
            endcase
            regs[0] = '0;
            pc = next;
        end
        return -1;
    endfunction

    task automatic bit_wait();
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx = 1'b0;
        bit_wait();
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            bit_wait();
        end
        rx = 1'b1;
        bit_wait();
    endtask

    // length byte, then each word least significant byte first
    task automatic upload_program();
        word_t w;
        uploading = 1'b1;
        send_byte(8'(prog.size()));
        foreach (prog[i]) begin
            w = prog[i];
            for (int k = 0; k < 4; k++) begin
                send_byte(w[8*k +: 8]);
            end
        end
        uploading = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        rx    = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (display_out !== 16'h0000) begin
            errors++;
            $display("[ERROR] %0t display_out: expected 0000, got %h", $time, display_out);
        end
        if (halted !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t halted: expected 0, got %b", $time, halted);
        end
    endtask

    // compares each display pulse against the model in order
    always @(negedge clk) begin
        if (!reset && display_valid === 1'b1) begin
            if (uploading) begin
                errors++;
                $display("%0t: display pulse while the program was still uploading", $time);
            end
            if (halted === 1'b1) begin
                errors++;
                $display("%0t: display pulse after the core halted", $time);
            end
            if (seen >= expected.size()) begin
                errors++;
                $display("%0t: display pulse %0d is more than the model produced", $time, seen);
            end else if (display_out !== expected[seen]) begin
                errors++;
                $display("[ERROR] %0t display_out: expected %h, got %h",
                         $time, expected[seen], display_out);
            end
            seen++;
        end
    end

    task automatic run_test(input string name);
        int n_instr;
        int limit;
        int cycles;
        int errs_before;
        errs_before = errors;
        if (prog.size() > MAX_WORDS) begin
            errors++;
            $display("%s: program has %0d words, more than %0d", name, prog.size(), MAX_WORDS);
        end
        n_instr = run_model();
        if (n_instr < 0) begin
            errors++;
            $display("%s: reference model never reached HALT", name);
            limit = 5 * MAX_STEPS;
        end else begin
            limit = 5 * (n_instr + 1) + 20;
        end
        seen = 0;
        apply_reset();
        bit_wait();
        upload_program();
        cycles = 0;
        while (halted !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            errors++;
            $display("%s: halted never rose within %0d cycles of the upload", name, limit);
        end else begin
            // window for a stray pulse after the halt
            repeat (20) @(negedge clk);
        end
        if (seen != expected.size()) begin
            errors++;
            $display("%s: saw %0d display pulses, model gives %0d", name, seen, expected.size());
        end
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok, %0d displays, %0d instructions", name, seen, n_instr);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic build_arith();
        prog.delete();
        prog.push_back(addi(1, 0, -7));
        prog.push_back(lui(2, 16'h8765));
        prog.push_back(addi(2, 2, 16'h4321));
        prog.push_back(addi(3, 0, 31));
        prog.push_back(addi(4, 0, 5));
        prog.push_back(addi(6, 0, 16));
        prog.push_back(show(2));
        // every operation on r2 and r1, low then high half
        for (int fn = 0; fn < 8; fn++) begin
            prog.push_back(alu_instr(fn, 5, 2, 1));
            prog.push_back(show(5));
            prog.push_back(alu_instr(ALU_SRL, 7, 5, 6));
            prog.push_back(show(7));
        end
        prog.push_back(alu_instr(ALU_SLL, 5, 1, 3));
        prog.push_back(alu_instr(ALU_SRL, 7, 5, 6));
        prog.push_back(show(7));
        prog.push_back(alu_instr(ALU_SRL, 5, 1, 3));
        prog.push_back(show(5));
        prog.push_back(alu_instr(ALU_SLT, 5, 1, 4));
        prog.push_back(show(5));
        prog.push_back(alu_instr(ALU_SLT, 5, 4, 1));
        prog.push_back(show(5));
        prog.push_back(halt_instr());
    endtask

    task automatic build_load_store();
        prog.delete();
        prog.push_back(addi(1, 0, 16'h1234));
        prog.push_back(lui(2, 16'hbeef));
        prog.push_back(addi(2, 2, 16'h0042));
        prog.push_back(addi(3, 0, 16'h0200));
        prog.push_back(addi(9, 0, 16));
        prog.push_back(alu_instr(ALU_XOR, 5, 1, 2));
        prog.push_back(encode(OP_SW, 0, 3, 1, 0));
        prog.push_back(encode(OP_SW, 0, 3, 2, 4));
        prog.push_back(encode(OP_SW, 0, 3, 5, 8));
        prog.push_back(encode(OP_LW, 6, 3, 0, 0));
        prog.push_back(show(6));
        prog.push_back(encode(OP_LW, 7, 3, 0, 4));
        prog.push_back(show(7));
        prog.push_back(alu_instr(ALU_SRL, 8, 7, 9));
        prog.push_back(show(8));
        prog.push_back(encode(OP_LW, 10, 3, 0, 8));
        prog.push_back(alu_instr(ALU_SRL, 11, 10, 9));
        prog.push_back(show(11));
        // r0 has to read back as zero
        prog.push_back(addi(0, 1, 16'h0055));
        prog.push_back(show(0));
        prog.push_back(encode(OP_LW, 0, 3, 0, 4));
        prog.push_back(show(0));
        prog.push_back(halt_instr());
    endtask

    task automatic build_control_flow();
        prog.delete();
        prog.push_back(addi(1, 0, 0));
        prog.push_back(addi(2, 0, 1));
        prog.push_back(addi(3, 0, 21));
        prog.push_back(alu_instr(ALU_ADD, 1, 1, 2));
        prog.push_back(addi(2, 2, 1));
        prog.push_back(encode(OP_BNE, 0, 2, 3, -3));
        prog.push_back(show(1));
        prog.push_back(encode(OP_BEQ, 0, 1, 1, 1));
        prog.push_back(show(2));
        prog.push_back(encode(OP_BEQ, 0, 1, 2, 1));
        prog.push_back(show(3));
        prog.push_back(encode(OP_JAL, 15, 0, 0, 2));
        prog.push_back(show(4));
        prog.push_back(halt_instr());
        // subroutine at word 14
        prog.push_back(addi(4, 0, 16'h0077));
        prog.push_back(show(15));
        prog.push_back(encode(OP_JR, 0, 15, 0, 0));
    endtask

    task automatic build_random();
        int rd;
        int rs;
        int rt;
        prog.delete();
        for (int k = 1; k < 8; k++) begin
            prog.push_back(addi(k, 0, int'($urandom)));
        end
        for (int k = 0; k < 24; k++) begin
            rd = 1 + int'($urandom % 7);
            rs = 1 + int'($urandom % 7);
            rt = 1 + int'($urandom % 7);
            if ($urandom % 3 == 0) begin
                prog.push_back(addi(rd, rs, int'($urandom)));
            end else begin
                prog.push_back(alu_instr(int'($urandom % 8), rd, rs, rt));
            end
            if (k % 4 == 3) begin
                prog.push_back(show(rd));
            end
        end
        for (int k = 1; k < 8; k++) begin
            prog.push_back(show(k));
        end
        prog.push_back(halt_instr());
    endtask

    task automatic build_undefined_halt();
        prog.delete();
        prog.push_back(addi(1, 0, 16'h0abc));
        prog.push_back(show(1));
        prog.push_back(addi(2, 0, 16'h0def));
        // opcode 0xa is not defined
        prog.push_back(32'ha000_0000);
        prog.push_back(show(2));
        prog.push_back(halt_instr());
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run still going after %0d ns, stopping", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        rx           = 1'b1;
        uploading    = 1'b0;
        seen         = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        build_arith();
        run_test("arith_logic");
        build_load_store();
        run_test("load_store");
        build_control_flow();
        run_test("control_flow");
        build_random();
        run_test("random_boot");
        build_undefined_halt();
        run_test("undefined_halt");
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int CLKS_PER_BIT = 868,
    parameter int MEM_WORDS    = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        rx,
    output logic [15:0] display_out,
    output logic        display_valid,
    output logic        halted
);
    import cpu_pkg::*;

    upload_if up_bus ();
    mem_if    mem_bus ();

    word_t    instr;
    decoded_t dec;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t wr_idx;
    word_t    rs_data;
    word_t    rt_data;
    word_t    wr_data;
    logic     wr_en;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    alu_op_e  alu_op;

    assign display_valid = mem_bus.display_strobe;

    upload_rx #(.CLKS_PER_BIT(CLKS_PER_BIT), .MEM_WORDS(MEM_WORDS)) u_upload_rx (
        .clk  (clk),
        .reset(reset),
        .rx   (rx),
        .up   (up_bus.source)
    );

    memory #(.MEM_WORDS(MEM_WORDS)) u_memory (
        .clk        (clk),
        .reset      (reset),
        .up         (up_bus.sink),
        .core       (mem_bus.slave),
        .display_out(display_out)
    );

    instruction_decoder u_decoder (
        .instr(instr),
        .dec  (dec)
    );

    registers u_registers (
        .clk    (clk),
        .reset  (reset),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .wr_en  (wr_en),
        .wr_idx (wr_idx),
        .wr_data(wr_data)
    );

    alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (alu_op),
        .result(alu_result)
    );

    control_unit u_control (
        .clk       (clk),
        .reset     (reset),
        .up        (up_bus.core),
        .mem       (mem_bus.master),
        .dec       (dec),
        .instr     (instr),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_op    (alu_op),
        .alu_result(alu_result),
        .halted    (halted)
    );

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic              clk,
    input  logic              reset,
    upload_if.core            up,
    mem_if.master             mem,
    input  cpu_pkg::decoded_t dec,
    output cpu_pkg::word_t    instr,
    output cpu_pkg::reg_idx_t rs_idx,
    output cpu_pkg::reg_idx_t rt_idx,
    input  cpu_pkg::word_t    rs_data,
    input  cpu_pkg::word_t    rt_data,
    output logic              wr_en,
    output cpu_pkg::reg_idx_t wr_idx,
    output cpu_pkg::word_t    wr_data,
    output cpu_pkg::word_t    alu_a,
    output cpu_pkg::word_t    alu_b,
    output cpu_pkg::alu_op_e  alu_op,
    input  cpu_pkg::word_t    alu_result,
    output logic              halted
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, DECODE, EXECUTE, MEM, WRITEBACK, HALTED} state_e;

    state_e state;
    word_t  pc;
    word_t  pc_link;
    word_t  pc_target;
    word_t  ir;
    word_t  op_a;
    word_t  op_b;
    word_t  alu_res;
    logic   branch_taken;
    logic   is_mem_op;
    logic   writes_reg;

    // decoder sees the fetched word directly during DECODE
    assign instr  = (state == DECODE) ? mem.rdata : ir;
    assign rs_idx = dec.rs;
    assign rt_idx = dec.rt;
    assign halted = state == HALTED;

    assign is_mem_op  = (dec.opcode == OP_LW) || (dec.opcode == OP_SW);
    assign writes_reg = (dec.opcode == OP_ALU) || (dec.opcode == OP_ADDI) ||
                        (dec.opcode == OP_LUI) || (dec.opcode == OP_LW) ||
                        (dec.opcode == OP_JAL);

    // operand select
    always_comb begin
        alu_op = dec.alu_op;
        alu_a  = op_a;
        alu_b  = dec.imm;
        if (dec.opcode == OP_ALU) begin
            alu_b = op_b;
        end else if (dec.opcode == OP_LUI) begin
            alu_a = '0;
            alu_b = {dec.imm[15:0], 16'h0000};
        end
    end

    always_comb begin
        case (dec.opcode)
            OP_BEQ:  branch_taken = op_a == op_b;
            OP_BNE:  branch_taken = op_a != op_b;
            OP_JAL:  branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    // fetch by word pc, data access by computed byte address
    assign mem.addr  = (state == MEM) ? alu_res : {pc[XLEN-3:0], 2'b00};
    assign mem.we    = (state == MEM) && (dec.opcode == OP_SW);
    assign mem.wdata = op_b;

    assign wr_en  = (state == WRITEBACK) && writes_reg;
    assign wr_idx = dec.rd;
    always_comb begin
        case (dec.opcode)
            OP_LW:   wr_data = mem.rdata;
            OP_JAL:  wr_data = {pc_link[XLEN-3:0], 2'b00};
            default: wr_data = alu_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE:      if (up.complete) state <= FETCH;
                FETCH:     state <= DECODE;
                DECODE:    state <= EXECUTE;
                EXECUTE:   state <= is_mem_op ? MEM : WRITEBACK;
                MEM:       state <= WRITEBACK;
                WRITEBACK: begin
                    pc    <= pc_target;
                    state <= (dec.opcode == OP_HALT) ? HALTED : FETCH;
                end
                HALTED:    state <= HALTED;
                default:   state <= IDLE;
            endcase
        end
    end

    // instruction and operand latches
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir      <= mem.rdata;
            op_a    <= rs_data;
            op_b    <= rt_data;
            pc_link <= pc + 1'b1;
        end
        if (state == EXECUTE) begin
            alu_res <= alu_result;
            if (dec.opcode == OP_JR) begin
                pc_target <= op_a >> 2;
            end else if (branch_taken) begin
                pc_target <= pc_link + dec.imm;
            end else begin
                pc_target <= pc_link;
            end
        end
    end

endmodule

// File: memory.sv
`timescale 1ns/1ps

module memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset,
    upload_if.sink      up,
    mem_if.slave        core,
    output logic [15:0] display_out
);
    import cpu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t         mem_array [MEM_WORDS];
    logic [AW-1:0] up_idx;
    logic [AW-1:0] core_idx;
    logic          is_display;
    logic          display_we;

    // byte address to word index, upper bits wrap
    assign up_idx     = up.addr[AW+1:2];
    assign core_idx   = core.addr[AW+1:2];
    assign is_display = core.addr == DISPLAY_ADDR;
    assign display_we = core.we && is_display;

    always_ff @(posedge clk) begin
        if (up.valid) begin
            // each upload byte lands in its own lane
            mem_array[up_idx][{up.addr[1:0], 3'b000} +: 8] <= up.data;
        end else if (core.we && !is_display) begin
            mem_array[core_idx] <= core.wdata;
        end
        core.rdata <= mem_array[core_idx];
    end

    // display register and its one-cycle strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            display_out         <= '0;
            core.display_strobe <= 1'b0;
        end else begin
            core.display_strobe <= display_we;
            if (display_we) begin
                display_out <= core.wdata[15:0];
            end
        end
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    logic [4:0] shamt;
    logic       less;

    assign shamt = b[4:0];
    // signed compare for SLT
    assign less  = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SLT: result = {{(XLEN - 1){1'b0}}, less};
            default: result = '0;
        endcase
    end

endmodule

// File: registers.sv
`timescale 1ns/1ps

module registers (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    rt_data,
    input  logic             wr_en,
    input  cpu_pkg::reg_idx_t wr_idx,
    input  cpu_pkg::word_t    wr_data
);
    import cpu_pkg::*;

    word_t regs [2**REG_IDX_W];

    // r0 is never written so it keeps its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

endmodule

// File: instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::decoded_t dec
);
    import cpu_pkg::*;

    always_comb begin
        opcode_e op;

        // undefined codes stop the core
        case (instr[31:28])
            OP_ALU, OP_ADDI, OP_LUI, OP_LW, OP_SW,
            OP_BEQ, OP_BNE, OP_JAL, OP_JR: op = opcode_e'(instr[31:28]);
            default:                       op = OP_HALT;
        endcase

        dec.opcode = op;
        dec.rd     = instr[27:24];
        dec.rs     = instr[23:20];
        dec.rt     = instr[19:16];
        dec.imm    = {{(XLEN - IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};

        // address and immediate math all go through the adder
        if (op == OP_ALU && !instr[3]) begin
            dec.alu_op = alu_op_e'(instr[3:0]);
        end else begin
            dec.alu_op = ALU_ADD;
        end
    end

endmodule

// File: upload_rx.sv
`timescale 1ns/1ps

module upload_rx #(
    parameter int CLKS_PER_BIT = 868,
    parameter int MEM_WORDS    = 256
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    upload_if.source up
);
    import cpu_pkg::*;

    // the length byte can announce at most 255 words
    localparam int MAX_BYTES = (MEM_WORDS < 256) ? 4 * MEM_WORDS : 1020;
    localparam int REM_W     = $clog2(MAX_BYTES + 1);

    typedef enum logic [2:0] {IDLE, START, DATA, STOP, DONE} state_e;

    state_e           state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             timer_en;
    logic             sample_tick;
    logic             bit_done;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             have_len;
    logic [REM_W-1:0] remaining;
    logic [REM_W-1:0] len_bytes;
    word_t            next_addr;

    baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) timer (
        .clk        (clk),
        .reset      (reset),
        .enable     (timer_en),
        .sample_tick(sample_tick),
        .bit_done   (bit_done)
    );

    assign timer_en = (state == START) || (state == DATA) || (state == STOP);

    // byte count of the program, clipped to the memory size
    always_comb begin
        int n_bytes;
        n_bytes = 4 * int'(shreg);
        if (n_bytes > MAX_BYTES) begin
            n_bytes = MAX_BYTES;
        end
        len_bytes = REM_W'(n_bytes);
    end

    // two-flop synchronizer, idle line is high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            have_len    <= 1'b0;
            up.valid    <= 1'b0;
            up.complete <= 1'b0;
        end else begin
            up.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    // glitch, not a real start bit
                    if (sample_tick && rx_sync) begin
                        state <= IDLE;
                    end else if (bit_done) begin
                        state   <= DATA;
                        bit_idx <= '0;
                    end
                end
                DATA: begin
                    if (sample_tick) begin
                        shreg <= {rx_sync, shreg[7:1]};
                    end
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    // back to idle at mid stop bit so the next start edge is seen
                    if (sample_tick) begin
                        state <= IDLE;
                        if (rx_sync && !have_len) begin
                            have_len  <= 1'b1;
                            remaining <= len_bytes;
                            next_addr <= '0;
                            if (len_bytes == '0) begin
                                state <= DONE;
                            end
                        end else if (rx_sync) begin
                            up.valid  <= 1'b1;
                            up.addr   <= next_addr;
                            up.data   <= shreg;
                            next_addr <= next_addr + 1'b1;
                            remaining <= remaining - 1'b1;
                            if (remaining == REM_W'(1)) begin
                                state <= DONE;
                            end
                        end
                    end
                end
                DONE: begin
                    up.complete <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    output logic sample_tick,
    output logic bit_done
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_COUNT = CNT_W'(CLKS_PER_BIT / 2);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] count;

    // restarts from zero whenever the receiver is idle
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            count <= '0;
        end else if (count == LAST_COUNT) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign sample_tick = enable && (count == HALF_COUNT);
    assign bit_done    = enable && (count == LAST_COUNT);

endmodule

// File: cpu_ifs.sv
`timescale 1ns/1ps

// program upload path from the receiver into memory
interface upload_if;
    import cpu_pkg::*;

    logic       valid;
    word_t      addr;
    logic [7:0] data;
    // held high once the whole program is in memory
    logic       complete;

    modport source (output valid, output addr, output data, output complete);
    modport sink   (input valid, input addr, input data);
    modport core   (input complete);
endinterface

// core side of the word memory, read data one cycle after addr
interface mem_if;
    import cpu_pkg::*;

    word_t addr;
    word_t wdata;
    logic  we;
    word_t rdata;
    logic  display_strobe;

    modport master (output addr, output wdata, output we, input rdata);
    modport slave  (input addr, input wdata, input we, output rdata, output display_strobe);
endinterface

// File: cpu_pkg.sv
package cpu_pkg;

    // datapath widths
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 16;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // stores to this byte address go to the display register
    localparam word_t DISPLAY_ADDR = 32'hFFFF_FFFC;

    // instruction bits 31..28
    typedef enum logic [3:0] {
        OP_ALU  = 4'h0,
        OP_ADDI = 4'h1,
        OP_LUI  = 4'h2,
        OP_LW   = 4'h3,
        OP_SW   = 4'h4,
        OP_BEQ  = 4'h5,
        OP_BNE  = 4'h6,
        OP_JAL  = 4'h7,
        OP_JR   = 4'h8,
        OP_HALT = 4'hF
    } opcode_e;

    // instruction bits 3..0 for OP_ALU
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6,
        ALU_SLT = 4'h7
    } alu_op_e;

    typedef struct packed {
        opcode_e  opcode;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    imm;
    } decoded_t;

endpackage
